//--- list.f
verilog/psram_pkg.sv
verilog/count_reg.sv
verilog/psram_controller.sv
verilog/burst_data_path.sv
verilog/psram_subsystem.sv
testbench/psram_model.sv
testbench/tb_psram_subsystem.sv

//--- testbench/tb_psram_subsystem.sv
`timescale 1ns/1ps

module tb_psram_subsystem;

    // Scoreboard window base and run limit
    localparam logic [psram_pkg::ADDR_WIDTH-1:0] WIN_BASE = 24'h01_2300;
    localparam int WATCHDOG_NS = (60 * 21 + 400) * 20;

    logic                                clk50MHz;
    logic                                reset;
    psram_pkg::psram_req_t               req;
    logic                                start;
    logic [psram_pkg::DATA_WIDTH-1:0]    wr_data;
    logic                                busy;
    logic                                wr_take;
    logic [psram_pkg::DATA_WIDTH-1:0]    rd_data;
    logic                                rd_valid;
    logic [psram_pkg::ADDR_WIDTH-1:0]    maddr;
    psram_pkg::psram_ctrl_t              mctrl;
    logic                                mclk;
    logic                                mcre;
    wire  [psram_pkg::DATA_WIDTH-1:0]    mdata;
    int                                  adv_count;

    // Mirror of every word written inside the window
    logic [psram_pkg::DATA_WIDTH-1:0]    sb [0:255];
    bit                                  written [0:255];

    // Expectations for the access in flight
    int                                  exp_busy_len;
    int                                  exp_takes;
    int                                  exp_valids;
    int                                  accepted;
    logic [psram_pkg::ADDR_WIDTH-1:0]    cur_addr;
    logic [psram_pkg::ADDR_WIDTH-1:0]    rd_ptr;
    logic [7:0]                          rd_idx;
    logic [psram_pkg::DATA_WIDTH-1:0]    exp_word;
    logic                                exp_known;

    // Observed per access
    int                                  busy_len;
    int                                  takes;
    int                                  valids;
    int                                  since_start;
    int                                  cycle;

    integer                              seed;
    int                                  errors;
    int                                  pass_count;
    int                                  fail_count;

    psram_subsystem dut (
        .clk50MHz (clk50MHz),
        .reset    (reset),
        .req      (req),
        .start    (start),
        .wr_data  (wr_data),
        .busy     (busy),
        .wr_take  (wr_take),
        .rd_data  (rd_data),
        .rd_valid (rd_valid),
        .maddr    (maddr),
        .mctrl    (mctrl),
        .mclk     (mclk),
        .mcre     (mcre),
        .mdata    (mdata)
    );

    psram_model model (
        .mclk      (mclk),
        .maddr     (maddr),
        .mctrl     (mctrl),
        .mdata     (mdata),
        .adv_count (adv_count)
    );

    initial begin
        clk50MHz = 1'b0;
        forever #10 clk50MHz = ~clk50MHz;
    end

    function automatic logic [7:0] sb_index(input logic [psram_pkg::ADDR_WIDTH-1:0] a);
        return 8'(a - WIN_BASE);
    endfunction

    // Distinct per address inside the window
    function automatic logic [psram_pkg::DATA_WIDTH-1:0] pattern_word(
        input logic [psram_pkg::ADDR_WIDTH-1:0] a
    );
        return a[15:0] ^ 16'h5a00;
    endfunction

    function automatic bit range_written(input logic [psram_pkg::ADDR_WIDTH-1:0] a,
                                         input int len);
        for (int i = 0; i < len; i++) begin
            if (!written[sb_index(a + psram_pkg::ADDR_WIDTH'(i))]) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    assign rd_idx    = sb_index(rd_ptr);
    assign exp_word  = sb[rd_idx];
    assign exp_known = written[rd_idx];

    // Burst observers are cleared on the accepting edge
    always @(posedge clk50MHz) begin
        cycle <= cycle + 1;
        busy_len <= (reset || !busy) ? 0 : busy_len + 1;
        if (reset || (!busy && start)) begin
            takes       <= 0;
            valids      <= 0;
            since_start <= 1;
        end
        else begin
            takes       <= takes + int'(wr_take);
            valids      <= valids + int'(rd_valid);
            since_start <= since_start + 1;
        end
        if (rd_valid) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    task automatic note_mismatch(input string msg);
        errors++;
        $display("mismatch at %0t: %s", $time, msg);
    endtask

    a_reset_quiet : assert property (@(posedge clk50MHz)
        (cycle > 0 && (reset || $past(reset))) |->
            (!busy && !wr_take && !rd_valid && mctrl == 4'b1111)
    ) else note_mismatch("host strobes or control pins active around reset");

    a_reset_mclk_low : assert property (@(negedge clk50MHz)
        (cycle > 1 && (reset || $past(reset))) |-> !mclk
    ) else note_mismatch("mclk running around reset");

    a_mcre_low : assert property (@(posedge clk50MHz)
        (cycle > 0) |-> !mcre
    ) else note_mismatch("mcre high, expected low");

    a_busy_length : assert property (@(posedge clk50MHz) disable iff (reset)
        $fell(busy) |-> busy_len == exp_busy_len
    ) else note_mismatch($sformatf("busy lasted %0d cycles, expected %0d",
                                   $sampled(busy_len), $sampled(exp_busy_len)));

    a_burst_counts : assert property (@(posedge clk50MHz) disable iff (reset)
        $fell(busy) |-> (takes == exp_takes && valids == exp_valids)
    ) else note_mismatch($sformatf("wr_take %0d rd_valid %0d, expected %0d and %0d",
                                   $sampled(takes), $sampled(valids),
                                   $sampled(exp_takes), $sampled(exp_valids)));

    a_single_adv : assert property (@(posedge clk50MHz) disable iff (reset)
        $fell(busy) |-> adv_count == accepted
    ) else note_mismatch("memory saw an address valid for an ignored start");

    a_first_take : assert property (@(posedge clk50MHz) disable iff (reset)
        $rose(wr_take) |-> since_start == 5
    ) else note_mismatch("first wr_take not five cycles after start");

    a_first_valid : assert property (@(posedge clk50MHz) disable iff (reset)
        $rose(rd_valid) |-> since_start == 6
    ) else note_mismatch("first rd_valid not six cycles after start");

    a_addr_held : assert property (@(posedge clk50MHz) disable iff (reset)
        busy |-> maddr == cur_addr
    ) else note_mismatch($sformatf("maddr %h, expected %h", $sampled(maddr),
                                   $sampled(cur_addr)));

    a_read_data : assert property (@(posedge clk50MHz) disable iff (reset)
        rd_valid |-> (exp_known && rd_data == exp_word)
    ) else note_mismatch($sformatf("rd_data %h at %h, expected %h", $sampled(rd_data),
                                   $sampled(rd_ptr), $sampled(exp_word)));

    // Runs one access and with poke pulses a second start while busy
    task automatic run_access(input logic [psram_pkg::ADDR_WIDTH-1:0] addr, input int len,
                              input bit write, input bit rand_data, input bit poke);
        int                               waited;
        int                               sent;
        logic [7:0]                       idx;
        logic [psram_pkg::DATA_WIDTH-1:0] word;

        waited = 0;
        sent   = 0;
        // One idle cycle keeps the previous end checks on the old expectations
        @(posedge clk50MHz);
        #2;
        exp_busy_len  = len + 5;
        exp_takes     = write ? len : 0;
        exp_valids    = write ? 0 : len;
        cur_addr      = addr;
        rd_ptr        = addr;
        accepted++;
        req.addr      = addr;
        req.burst_len = psram_pkg::BURST_WIDTH'(len);
        req.write     = write;
        start         = 1'b1;
        @(posedge clk50MHz);
        #2;
        start = 1'b0;
        if (!busy) begin
            errors++;
            $display("request at %h was not accepted", addr);
        end
        while (busy && waited < 30) begin
            if (wr_take) begin
                idx          = sb_index(addr + psram_pkg::ADDR_WIDTH'(sent));
                word         = rand_data ? 16'($random(seed))
                                         : pattern_word(addr + psram_pkg::ADDR_WIDTH'(sent));
                wr_data      = word;
                sb[idx]      = word;
                written[idx] = 1'b1;
                sent++;
            end
            start = poke && (waited == 1);
            if (poke && waited == 1) begin
                req.addr      = addr ^ 24'h00_0040;
                req.burst_len = psram_pkg::BURST_WIDTH'(len + 3);
                req.write     = !write;
            end
            @(posedge clk50MHz);
            #2;
            waited++;
        end
        start = 1'b0;
        if (busy) begin
            errors++;
            $display("access at %h did not finish in 30 cycles", addr);
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        repeat (2) @(posedge clk50MHz);
        #2;
        if (errors == errors_before) begin
            pass_count++;
            $display("%s: passed", name);
        end
        else begin
            fail_count++;
            $display("%s: failed with %0d errors", name, errors - errors_before);
        end
    endtask

    initial begin
        int                               err_before;
        int                               n;
        int                               len;
        bit                               wr;
        logic [psram_pkg::ADDR_WIDTH-1:0] addr;

        seed         = 11;
        errors       = 0;
        pass_count   = 0;
        fail_count   = 0;
        accepted     = 0;
        cycle        = 0;
        busy_len     = 0;
        takes        = 0;
        valids       = 0;
        since_start  = 0;
        exp_busy_len = 0;
        exp_takes    = 0;
        exp_valids   = 0;
        cur_addr     = WIN_BASE;
        rd_ptr       = WIN_BASE;
        req          = '0;
        start        = 1'b0;
        wr_data      = '0;
        reset        = 1'b1;
        for (n = 0; n < 256; n++) begin
            written[n] = 1'b0;
        end

        err_before = errors;
        repeat (3) @(posedge clk50MHz);
        #2;
        reset = 1'b0;
        repeat (2) @(posedge clk50MHz);
        #2;
        finish_test("reset state", err_before);

        err_before = errors;
        run_access(WIN_BASE + 24'd100, 1, 1'b1, 1'b0, 1'b0);
        run_access(WIN_BASE + 24'd100, 1, 1'b0, 1'b0, 1'b0);
        finish_test("single word write and read", err_before);

        // Length 16 goes out encoded as zero
        err_before = errors;
        for (n = 0; n < 3; n++) begin
            len = (n == 0) ? 1 : (n == 1) ? 4 : 16;
            run_access(WIN_BASE + 24'd128, len, 1'b1, 1'b1, 1'b0);
            run_access(WIN_BASE + 24'd128, len, 1'b0, 1'b0, 1'b0);
        end
        finish_test("burst timing", err_before);

        err_before = errors;
        run_access(WIN_BASE, 16, 1'b1, 1'b0, 1'b0);
        run_access(WIN_BASE, 16, 1'b0, 1'b0, 1'b0);
        run_access(WIN_BASE + 24'd3, 5, 1'b0, 1'b0, 1'b0);
        finish_test("burst data order", err_before);

        err_before = errors;
        run_access(WIN_BASE + 24'd200, 8, 1'b1, 1'b1, 1'b1);
        run_access(WIN_BASE + 24'd200, 8, 1'b0, 1'b0, 1'b1);
        finish_test("ignored start", err_before);

        // A read over unwritten words is turned into a write
        err_before = errors;
        for (n = 0; n < 40; n++) begin
            addr = WIN_BASE + psram_pkg::ADDR_WIDTH'($random(seed) & 31);
            len  = ($random(seed) & 15) + 1;
            wr   = $random(seed) & 1;
            if (!wr && !range_written(addr, len)) begin
                wr = 1'b1;
            end
            run_access(addr, len, wr, 1'b1, 1'b0);
        end
        finish_test("random traffic", err_before);

        $display("tests passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0 && errors == 0) begin
            $display("Test completed successfully");
        end
        else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before all tests finished");
        $display("Test failed");
        $finish;
    end

endmodule

//--- testbench/psram_model.sv
`timescale 1ns/1ps

module psram_model (
    input  logic                                mclk,
    input  logic [psram_pkg::ADDR_WIDTH-1:0]    maddr,
    input  psram_pkg::psram_ctrl_t              mctrl,
    inout  wire  [psram_pkg::DATA_WIDTH-1:0]    mdata,
    output int                                  adv_count
);

    // Sparse storage, only written words exist
    logic [psram_pkg::DATA_WIDTH-1:0] mem [int unsigned];

    logic                             active;
    logic                             is_write;
    logic [psram_pkg::ADDR_WIDTH-1:0] base;
    logic [psram_pkg::ADDR_WIDTH-1:0] word_addr;
    logic [psram_pkg::DATA_WIDTH-1:0] rd_word;
    int                               clk_count;

    initial begin
        active    = 1'b0;
        is_write  = 1'b0;
        base      = '0;
        rd_word   = '0;
        clk_count = 0;
        adv_count = 0;
    end

    // Unwritten locations return a word built from the full address
    function automatic logic [psram_pkg::DATA_WIDTH-1:0] fill_word(
        input logic [psram_pkg::ADDR_WIDTH-1:0] a
    );
        return a[15:0] ^ {8'h00, a[23:16]} ^ 16'h3c5a;
    endfunction

    function automatic logic [psram_pkg::DATA_WIDTH-1:0] fetch_word(
        input logic [psram_pkg::ADDR_WIDTH-1:0] a
    );
        if (mem.exists(a)) begin
            return mem[a];
        end
        return fill_word(a);
    endfunction

    always @(posedge mclk) begin
        if (mctrl.ce_n) begin
            active <= 1'b0;
        end
        else if (!mctrl.adv_n) begin
            // Address valid, we_n low here marks a write burst
            active    <= 1'b1;
            base      <= maddr;
            is_write  <= !mctrl.we_n;
            clk_count <= 0;
            adv_count <= adv_count + 1;
        end
        else if (active) begin
            clk_count <= clk_count + 1;
            if (is_write && clk_count >= psram_pkg::RW_LATENCY) begin
                word_addr = base + psram_pkg::ADDR_WIDTH'(clk_count - psram_pkg::RW_LATENCY);
                mem[word_addr] = mdata;
            end
            // Read words lead the capture edge by one memory clock
            if (!is_write && clk_count >= psram_pkg::RW_LATENCY - 1) begin
                word_addr = base + psram_pkg::ADDR_WIDTH'(clk_count - (psram_pkg::RW_LATENCY - 1));
                rd_word <= fetch_word(word_addr);
            end
        end
    end

    assign mdata = (!mctrl.ce_n && !mctrl.oe_n) ? rd_word : 'z;

endmodule

//--- verilog/psram_subsystem.sv
`timescale 1ns/1ps

module psram_subsystem (
    input  logic                                clk50MHz,
    input  logic                                reset,

    // Host side
    input  psram_pkg::psram_req_t               req,
    input  logic                                start,
    input  logic [psram_pkg::DATA_WIDTH-1:0]    wr_data,
    output logic                                busy,
    output logic                                wr_take,
    output logic [psram_pkg::DATA_WIDTH-1:0]    rd_data,
    output logic                                rd_valid,

    // Memory side
    output logic [psram_pkg::ADDR_WIDTH-1:0]    maddr,
    output psram_pkg::psram_ctrl_t              mctrl,
    output logic                                mclk,
    output logic                                mcre,
    inout  wire  [psram_pkg::DATA_WIDTH-1:0]    mdata
);

    logic data_phase;
    logic write_phase;

    psram_controller ctrl (
        .clk50MHz    (clk50MHz),
        .reset       (reset),
        .req         (req),
        .start       (start),
        .busy        (busy),
        .wr_take     (wr_take),
        .data_phase  (data_phase),
        .write_phase (write_phase),
        .maddr       (maddr),
        .mctrl       (mctrl),
        .mclk        (mclk),
        .mcre        (mcre)
    );

    burst_data_path data_path (
        .clk50MHz    (clk50MHz),
        .reset       (reset),
        .data_phase  (data_phase),
        .write_phase (write_phase),
        .wr_data     (wr_data),
        .mdata       (mdata),
        .rd_data     (rd_data),
        .rd_valid    (rd_valid)
    );

endmodule

//--- verilog/burst_data_path.sv
`timescale 1ns/1ps

module burst_data_path (
    input  logic                                clk50MHz,
    input  logic                                reset,
    input  logic                                data_phase,
    input  logic                                write_phase,
    input  logic [psram_pkg::DATA_WIDTH-1:0]    wr_data,
    inout  wire  [psram_pkg::DATA_WIDTH-1:0]    mdata,
    output logic [psram_pkg::DATA_WIDTH-1:0]    rd_data,
    output logic                                rd_valid
);

    logic drive_en;
    logic capture;

    logic [psram_pkg::DATA_WIDTH-1:0] rd_data_q;

    // Host word goes straight to the pins in a write data cycle
    assign drive_en = data_phase && write_phase;
    assign mdata    = drive_en ? wr_data : 'z;

    // Read data cycles are the data cycles that are not writes
    assign capture = data_phase && !write_phase;

    // Read word register
    always_ff @(posedge clk50MHz) begin
        if (capture) begin
            rd_data_q <= mdata;
        end
    end

    // Valid strobe follows the capture edge
    always_ff @(posedge clk50MHz) begin
        if (reset) begin
            rd_valid <= 1'b0;
        end
        else begin
            rd_valid <= capture;
        end
    end

    assign rd_data = rd_data_q;

    // Bus must be released whenever the controller is not writing
    a_bus_released : assert property (
        @(posedge clk50MHz) disable iff (reset)
        !write_phase |-> !drive_en
    ) else $error("burst_data_path: mdata driven outside write data");

    // Write strobe from the controller only ever comes inside a data state
    a_write_in_data : assert property (
        @(posedge clk50MHz) disable iff (reset)
        write_phase |-> data_phase
    ) else $error("burst_data_path: write_phase outside data_phase");

endmodule

//--- verilog/psram_controller.sv
`timescale 1ns/1ps

module psram_controller (
    input  logic                                clk50MHz,
    input  logic                                reset,
    input  psram_pkg::psram_req_t               req,
    input  logic                                start,
    output logic                                busy,
    output logic                                wr_take,
    output logic                                data_phase,
    output logic                                write_phase,
    output logic [psram_pkg::ADDR_WIDTH-1:0]    maddr,
    output psram_pkg::psram_ctrl_t              mctrl,
    output logic                                mclk,
    output logic                                mcre
);

    psram_pkg::psram_state_t state;
    psram_pkg::psram_state_t next_state;

    // Request held for the whole access
    psram_pkg::psram_req_t req_q;

    logic accept;

    logic                                  lat_clear;
    logic                                  lat_en;
    logic [psram_pkg::LATENCY_WIDTH-1:0]   lat_count;
    logic                                  lat_done;

    logic                                  burst_clear;
    logic                                  burst_en;
    logic [psram_pkg::BURST_WIDTH-1:0]     burst_count;
    logic [psram_pkg::BURST_WIDTH-1:0]     burst_last;
    logic                                  burst_done;

    logic mclk_run;
    logic mclk_en_q;

    assign busy   = (state != psram_pkg::ST_IDLE);
    assign accept = (state == psram_pkg::ST_IDLE) && start;

    always_ff @(posedge clk50MHz) begin
        if (accept) begin
            req_q <= req;
        end
    end

    // Latency counter runs only in the two wait states
    assign lat_en    = !reset && ((state == psram_pkg::ST_READ_WAIT) ||
                                  (state == psram_pkg::ST_WRITE_WAIT));
    assign lat_clear = !lat_en;
    assign lat_done  = (lat_count == psram_pkg::LATENCY_WIDTH'(psram_pkg::RW_LATENCY - 1));

    count_reg #(
        .WIDTH (psram_pkg::LATENCY_WIDTH)
    ) latency_counter (
        .clk50MHz (clk50MHz),
        .clear    (lat_clear),
        .en       (lat_en),
        .count    (lat_count)
    );

    // Burst counter runs in the data states
    assign burst_en    = !reset && data_phase;
    assign burst_clear = !burst_en;

    // Length zero wraps to 15 here, giving a 16 word burst
    assign burst_last = req_q.burst_len - psram_pkg::BURST_WIDTH'(1);
    assign burst_done = (burst_count == burst_last);

    count_reg #(
        .WIDTH (psram_pkg::BURST_WIDTH)
    ) burst_counter (
        .clk50MHz (clk50MHz),
        .clear    (burst_clear),
        .en       (burst_en),
        .count    (burst_count)
    );

    always_ff @(posedge clk50MHz) begin
        if (reset) begin
            state <= psram_pkg::ST_IDLE;
        end
        else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            psram_pkg::ST_IDLE: begin
                if (start) begin
                    next_state = req.write ? psram_pkg::ST_WRITE_WAIT
                                           : psram_pkg::ST_READ_WAIT;
                end
            end
            psram_pkg::ST_READ_WAIT: begin
                if (lat_done) begin
                    next_state = psram_pkg::ST_READ_DATA;
                end
            end
            psram_pkg::ST_READ_DATA: begin
                if (burst_done) begin
                    next_state = psram_pkg::ST_FINISH;
                end
            end
            psram_pkg::ST_WRITE_WAIT: begin
                if (lat_done) begin
                    next_state = psram_pkg::ST_WRITE_DATA;
                end
            end
            psram_pkg::ST_WRITE_DATA: begin
                if (burst_done) begin
                    next_state = psram_pkg::ST_FINISH;
                end
            end
            default: begin
                next_state = psram_pkg::ST_IDLE;
            end
        endcase
    end

    assign data_phase  = (state == psram_pkg::ST_READ_DATA) ||
                         (state == psram_pkg::ST_WRITE_DATA);
    assign write_phase = (state == psram_pkg::ST_WRITE_DATA);
    assign wr_take     = write_phase;

    // Address follows the host during the address valid cycle
    assign maddr = (state == psram_pkg::ST_IDLE) ? req.addr : req_q.addr;

    // Control pin decode, all pins idle high by default
    always_comb begin
        mctrl = '1;
        case (state)
            psram_pkg::ST_IDLE: begin
                mctrl.ce_n  = !start;
                mctrl.adv_n = !start;
                mctrl.we_n  = !(start && req.write);
            end
            psram_pkg::ST_READ_WAIT,
            psram_pkg::ST_WRITE_WAIT: begin
                mctrl.ce_n = 1'b0;
            end
            psram_pkg::ST_READ_DATA: begin
                mctrl.ce_n = 1'b0;
                mctrl.oe_n = 1'b0;
            end
            psram_pkg::ST_WRITE_DATA: begin
                mctrl.ce_n = 1'b0;
                mctrl.we_n = 1'b0;
            end
            default: begin
                mctrl = '1;
            end
        endcase
    end

    // Clock runs from the address valid cycle through finish
    assign mclk_run = busy || start;

    // Enable changes while clk50MHz is low, so mclk has no glitch
    always_ff @(negedge clk50MHz) begin
        if (reset) begin
            mclk_en_q <= 1'b0;
        end
        else begin
            mclk_en_q <= mclk_run;
        end
    end

    assign mclk = clk50MHz & mclk_en_q;

    // Configuration register access unused, pin parked low
    always_ff @(posedge clk50MHz) begin
        mcre <= 1'b0;
    end

    a_adv_only_idle : assert property (
        @(posedge clk50MHz) disable iff (reset)
        (state != psram_pkg::ST_IDLE) |-> mctrl.adv_n
    ) else $error("psram_controller: adv_n low outside idle");

    a_oe_we_exclusive : assert property (
        @(posedge clk50MHz) disable iff (reset)
        !(!mctrl.oe_n && !mctrl.we_n)
    ) else $error("psram_controller: oe_n and we_n low together");

    // A start during an access must not disturb it
    a_start_while_busy : assert property (
        @(posedge clk50MHz) disable iff (reset)
        (busy && start) |=> $stable(req_q) && (state != psram_pkg::ST_IDLE ||
                                               $past(state) == psram_pkg::ST_FINISH)
    ) else $error("psram_controller: start while busy altered the access");

endmodule

//--- verilog/count_reg.sv
`timescale 1ns/1ps

module count_reg #(
    parameter int WIDTH = 4
) (
    input  logic             clk50MHz,
    input  logic             clear,
    input  logic             en,
    output logic [WIDTH-1:0] count
);

    // Clear wins over enable, count wraps at the top
    always_ff @(posedge clk50MHz) begin
        if (clear) begin
            count <= '0;
        end
        else if (en) begin
            count <= count + WIDTH'(1);
        end
    end

    // The controller derives both strobes from one state, never together
    a_clear_en_exclusive : assert property (
        @(posedge clk50MHz) !(clear && en)
    ) else $error("count_reg: clear and en high in the same cycle");

endmodule

//--- verilog/psram_pkg.sv
package psram_pkg;

    // Memory geometry
    localparam int ADDR_WIDTH = 24;
    localparam int DATA_WIDTH = 16;

    // Burst length field, zero encodes a 16 word burst
    localparam int BURST_WIDTH = 4;

    // Fixed read/write latency in memory clocks
    localparam int RW_LATENCY    = 4;
    localparam int LATENCY_WIDTH = 2;

    // Access FSM states
    typedef enum logic [2:0] {
        ST_IDLE       = 3'd0,
        ST_READ_WAIT  = 3'd1,
        ST_READ_DATA  = 3'd2,
        ST_WRITE_WAIT = 3'd3,
        ST_WRITE_DATA = 3'd4,
        ST_FINISH     = 3'd5
    } psram_state_t;

    // Host request, one per access
    typedef struct packed {
        logic [ADDR_WIDTH-1:0]  addr;
        logic [BURST_WIDTH-1:0] burst_len;
        logic                   write;
    } psram_req_t;

    // Active low memory control pins
    typedef struct packed {
        logic ce_n;
        logic adv_n;
        logic oe_n;
        logic we_n;
    } psram_ctrl_t;

endpackage
